//--- hw/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    // Threads per warp.
    localparam int num_lanes = 4;

    // Pipeline depths in enabled cycles.
    localparam int latency_imul = 3;
    localparam int latency_idiv = 5;

    localparam int istag_bits = 4;

    // Encoding follows funct3 of the M extension.
    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } mdu_op_e;

    typedef logic [istag_bits-1:0] istag_t;

    // Per-lane words at the widths used along the datapath.
    typedef logic [num_lanes-1:0][31:0] lane_data_t;
    typedef logic [num_lanes-1:0][32:0] lane_opnd_t;
    typedef logic [num_lanes-1:0][63:0] lane_prod_t;

    typedef struct packed {
        mdu_op_e    op;
        lane_data_t rs1;
        lane_data_t rs2;
        istag_t     tag;
    } mdu_req_t;

    typedef struct packed {
        istag_t     tag;
        lane_data_t data;
    } mdu_rsp_t;

    // Travels beside the multiplier.
    typedef struct packed {
        istag_t tag;
        logic   take_low;
    } mdu_mul_side_t;

    // Travels beside the divider.
    typedef struct packed {
        istag_t                 tag;
        logic [num_lanes-1:0]   take_quot;
    } mdu_div_side_t;

endpackage

`default_nettype wire

//--- hw/mdu_operand_prep.sv
`default_nettype none

module mdu_operand_prep (
    input  logic                   req_valid,
    input  mdu_pkg::mdu_req_t      req,
    output logic                   mul_valid,
    output logic                   div_valid,
    output mdu_pkg::lane_opnd_t    mul_a,
    output mdu_pkg::lane_opnd_t    mul_b,
    output mdu_pkg::lane_opnd_t    div_n,
    output mdu_pkg::lane_opnd_t    div_d,
    output mdu_pkg::mdu_mul_side_t mul_side,
    output mdu_pkg::mdu_div_side_t div_side
);

    logic is_div;
    logic is_quot;
    logic mul_a_signed;
    logic mul_b_signed;
    logic div_signed;

    assign is_div  = req.op inside {mdu_pkg::op_div, mdu_pkg::op_divu,
                                    mdu_pkg::op_rem, mdu_pkg::op_remu};
    assign is_quot = req.op inside {mdu_pkg::op_div, mdu_pkg::op_divu};

    // MULHSU keeps rs1 signed only.
    assign mul_a_signed = (req.op != mdu_pkg::op_mulhu);
    assign mul_b_signed = req.op inside {mdu_pkg::op_mul, mdu_pkg::op_mulh};
    assign div_signed   = req.op inside {mdu_pkg::op_div, mdu_pkg::op_rem};

    assign mul_valid = req_valid && !is_div;
    assign div_valid = req_valid && is_div;

    always_comb begin
        mul_side.tag      = req.tag;
        mul_side.take_low = (req.op == mdu_pkg::op_mul);
        div_side.tag      = req.tag;

        for (int i = 0; i < mdu_pkg::num_lanes; i++) begin
            mul_a[i] = {mul_a_signed & req.rs1[i][31], req.rs1[i]};
            mul_b[i] = {mul_b_signed & req.rs2[i][31], req.rs2[i]};
            div_n[i] = {div_signed & req.rs1[i][31], req.rs1[i]};
            div_d[i] = {div_signed & req.rs2[i][31], req.rs2[i]};
            div_side.take_quot[i] = is_quot;

            // Zero divisor, so divide by one instead.
            if (req.rs2[i] == 32'd0) begin
                div_d[i] = 33'd1;
                if (is_quot) begin
                    div_n[i] = {1'b0, 32'hffff_ffff};
                end else begin
                    // Quotient of n / 1 is the dividend.
                    div_side.take_quot[i] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mdu_multiplier.sv
`default_nettype none

module mdu_multiplier (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  mdu_pkg::lane_opnd_t a,
    input  mdu_pkg::lane_opnd_t b,
    output mdu_pkg::lane_prod_t product
);

    logic [mdu_pkg::num_lanes-1:0][65:0] full;
    mdu_pkg::lane_prod_t                 stage [mdu_pkg::latency_imul];

    // Full 66-bit signed products.
    always_comb begin
        for (int i = 0; i < mdu_pkg::num_lanes; i++) begin
            full[i] = $signed(a[i]) * $signed(b[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < mdu_pkg::latency_imul; s++) begin
                stage[s] <= '0;
            end
        end else if (enable) begin
            for (int i = 0; i < mdu_pkg::num_lanes; i++) begin
                stage[0][i] <= full[i][63:0];
            end
            for (int s = 1; s < mdu_pkg::latency_imul; s++) begin
                stage[s] <= stage[s-1];
            end
        end
    end

    assign product = stage[mdu_pkg::latency_imul-1];

endmodule

`default_nettype wire

//--- hw/mdu_divider.sv
`default_nettype none

module mdu_divider (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  mdu_pkg::lane_opnd_t numer,
    input  mdu_pkg::lane_opnd_t denom,
    output mdu_pkg::lane_data_t quotient,
    output mdu_pkg::lane_data_t remainder
);

    logic [mdu_pkg::num_lanes-1:0][32:0] quot_full;
    logic [mdu_pkg::num_lanes-1:0][32:0] rem_full;

    mdu_pkg::lane_data_t quot_stage [mdu_pkg::latency_idiv];
    mdu_pkg::lane_data_t rem_stage  [mdu_pkg::latency_idiv];

    // Truncating division; 33-bit operands absorb the overflow case.
    always_comb begin
        for (int i = 0; i < mdu_pkg::num_lanes; i++) begin
            quot_full[i] = $signed(numer[i]) / $signed(denom[i]);
            rem_full[i]  = $signed(numer[i]) % $signed(denom[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < mdu_pkg::latency_idiv; s++) begin
                quot_stage[s] <= '0;
                rem_stage[s]  <= '0;
            end
        end else if (enable) begin
            for (int i = 0; i < mdu_pkg::num_lanes; i++) begin
                quot_stage[0][i] <= quot_full[i][31:0];
                rem_stage[0][i]  <= rem_full[i][31:0];
            end
            for (int s = 1; s < mdu_pkg::latency_idiv; s++) begin
                quot_stage[s] <= quot_stage[s-1];
                rem_stage[s]  <= rem_stage[s-1];
            end
        end
    end

    assign quotient  = quot_stage[mdu_pkg::latency_idiv-1];
    assign remainder = rem_stage[mdu_pkg::latency_idiv-1];

endmodule

`default_nettype wire

//--- hw/mdu_delay_line.sv
`default_nettype none

module mdu_delay_line #(
    parameter int  depth     = 2,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    logic [depth-1:0] valid_q;
    payload_t         payload_q [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q[0] <= in_valid;
            for (int s = 1; s < depth; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            payload_q[0] <= in_payload;
            for (int s = 1; s < depth; s++) begin
                payload_q[s] <= payload_q[s-1];
            end
        end
    end

    assign out_valid   = valid_q[depth-1];
    assign out_payload = payload_q[depth-1];

endmodule

`default_nettype wire

//--- hw/mdu_commit_ctrl.sv
`default_nettype none

module mdu_commit_ctrl (
    input  logic                   mul_out_valid,
    input  mdu_pkg::mdu_mul_side_t mul_out_side,
    input  mdu_pkg::lane_prod_t    product,
    input  logic                   div_out_valid,
    input  mdu_pkg::mdu_div_side_t div_out_side,
    input  mdu_pkg::lane_data_t    quotient,
    input  mdu_pkg::lane_data_t    remainder,
    input  logic                   rsp_ready,
    output logic                   stall_mul,
    output logic                   stall_div,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output mdu_pkg::mdu_rsp_t      rsp
);

    mdu_pkg::lane_data_t mul_data;
    mdu_pkg::lane_data_t div_data;

    assign rsp_valid = mul_out_valid || div_out_valid;

    // Commit port back-pressure freezes everything.
    assign stall_mul = rsp_valid && !rsp_ready;

    // On a collision the divide waits for the multiply.
    assign stall_div = stall_mul || (mul_out_valid && div_out_valid);

    assign req_ready = !(stall_mul || stall_div);

    always_comb begin
        for (int i = 0; i < mdu_pkg::num_lanes; i++) begin
            mul_data[i] = mul_out_side.take_low ? product[i][31:0] : product[i][63:32];
            div_data[i] = div_out_side.take_quot[i] ? quotient[i] : remainder[i];
        end
    end

    assign rsp.tag  = mul_out_valid ? mul_out_side.tag : div_out_side.tag;
    assign rsp.data = mul_out_valid ? mul_data : div_data;

endmodule

`default_nettype wire

//--- hw/mdu_top.sv
`default_nettype none

module mdu_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  mdu_pkg::mdu_req_t req,
    output logic              req_ready,
    output logic              rsp_valid,
    output mdu_pkg::mdu_rsp_t rsp,
    input  logic              rsp_ready
);

    logic req_fire;

    logic                   mul_valid;
    logic                   div_valid;
    mdu_pkg::lane_opnd_t    mul_a;
    mdu_pkg::lane_opnd_t    mul_b;
    mdu_pkg::lane_opnd_t    div_n;
    mdu_pkg::lane_opnd_t    div_d;
    mdu_pkg::mdu_mul_side_t mul_side;
    mdu_pkg::mdu_div_side_t div_side;

    mdu_pkg::lane_prod_t product;
    mdu_pkg::lane_data_t quotient;
    mdu_pkg::lane_data_t remainder;

    logic                   mul_out_valid;
    logic                   div_out_valid;
    mdu_pkg::mdu_mul_side_t mul_out_side;
    mdu_pkg::mdu_div_side_t div_out_side;

    logic stall_mul;
    logic stall_div;

    // A held request must not enter the multiply path while the divide is frozen.
    assign req_fire = req_valid && req_ready;

    mdu_operand_prep operand_prep (
        .req_valid (req_fire),
        .req       (req),
        .mul_valid (mul_valid),
        .div_valid (div_valid),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .div_n     (div_n),
        .div_d     (div_d),
        .mul_side  (mul_side),
        .div_side  (div_side)
    );

    mdu_multiplier multiplier (
        .clk     (clk),
        .reset   (reset),
        .enable  (!stall_mul),
        .a       (mul_a),
        .b       (mul_b),
        .product (product)
    );

    mdu_divider divider (
        .clk       (clk),
        .reset     (reset),
        .enable    (!stall_div),
        .numer     (div_n),
        .denom     (div_d),
        .quotient  (quotient),
        .remainder (remainder)
    );

    mdu_delay_line #(
        .depth     (mdu_pkg::latency_imul),
        .payload_t (mdu_pkg::mdu_mul_side_t)
    ) mul_delay (
        .clk         (clk),
        .reset       (reset),
        .enable      (!stall_mul),
        .in_valid    (mul_valid),
        .in_payload  (mul_side),
        .out_valid   (mul_out_valid),
        .out_payload (mul_out_side)
    );

    mdu_delay_line #(
        .depth     (mdu_pkg::latency_idiv),
        .payload_t (mdu_pkg::mdu_div_side_t)
    ) div_delay (
        .clk         (clk),
        .reset       (reset),
        .enable      (!stall_div),
        .in_valid    (div_valid),
        .in_payload  (div_side),
        .out_valid   (div_out_valid),
        .out_payload (div_out_side)
    );

    mdu_commit_ctrl commit_ctrl (
        .mul_out_valid (mul_out_valid),
        .mul_out_side  (mul_out_side),
        .product       (product),
        .div_out_valid (div_out_valid),
        .div_out_side  (div_out_side),
        .quotient      (quotient),
        .remainder     (remainder),
        .rsp_ready     (rsp_ready),
        .stall_mul     (stall_mul),
        .stall_div     (stall_div),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

endmodule

`default_nettype wire

//--- bench/mdu_assert.sv
`default_nettype none

module mdu_assert (
    input logic              clk,
    input logic              reset,
    input logic              req_ready,
    input logic              rsp_valid,
    input mdu_pkg::mdu_rsp_t rsp,
    input logic              rsp_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // A stalled response is held until it is taken.
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else $error("stalled response was dropped or changed");

    quiet_after_reset: assert property (
        @(posedge clk) $past(reset) |-> !rsp_valid
    ) else $error("rsp_valid high in the cycle after reset");

    no_accept_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |-> !req_ready
    ) else $error("req_ready high while a response is stalled");

endmodule

bind mdu_top mdu_assert assert0 (
    .clk       (clk),
    .reset     (reset),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready)
);

`default_nettype wire

//--- bench/mdu_tb.sv
`default_nettype none

module mdu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_tags     = 1 << mdu_pkg::istag_bits;
    localparam int num_requests = 3000;

    // Unstalled response times after acceptance.
    localparam int mul_cycles = 3;
    localparam int div_cycles = 5;

    logic              clk = 1'b0;
    logic              reset;
    logic              req_valid;
    mdu_pkg::mdu_req_t req;
    logic              req_ready;
    logic              rsp_valid;
    mdu_pkg::mdu_rsp_t rsp;
    logic              rsp_ready;

    logic [31:0]         rng_state;
    mdu_pkg::lane_data_t exp_data [num_tags];
    mdu_pkg::mdu_op_e    exp_op   [num_tags];
    logic [num_tags-1:0] exp_busy;
    mdu_pkg::istag_t     next_tag;
    mdu_pkg::istag_t     last_tag;
    mdu_pkg::mdu_op_e    forced_op;
    logic                force_op;
    logic                req_accepted;
    logic                rsp_seen;
    int                  issued;
    int                  outstanding;
    int                  req_wait;

    mdu_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input mdu_pkg::lane_data_t expected,
                              input mdu_pkg::lane_data_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_tag(input string name, input mdu_pkg::istag_t expected,
                             input mdu_pkg::istag_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %s expected tag %0d actual tag %0d", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            fail_run($sformatf("ERR %s expected %0d cycles actual %0d cycles",
                               name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Edge values one time in four.
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        logic [31:0] val;
        r   = next_rand();
        val = next_rand();
        if (r[1:0] == 2'd0) begin
            case (r[3:2])
                2'd0:    val = 32'h0000_0000;
                2'd1:    val = 32'hffff_ffff;
                default: val = 32'h8000_0000;
            endcase
        end
        return val;
    endfunction

    function automatic logic [31:0] pick_divisor();
        logic [31:0] r;
        r = next_rand();
        return (r[2:0] == 3'd0) ? 32'd0 : pick_operand();
    endfunction

    // RISC-V M results for one lane.
    function automatic logic [31:0] model_lane(input mdu_pkg::mdu_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] za;
        logic signed [63:0] zb;
        logic signed [63:0] full;
        logic               overflow;
        sa       = {{32{a[31]}}, a};
        sb       = {{32{b[31]}}, b};
        za       = {32'd0, a};
        zb       = {32'd0, b};
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        full     = '0;
        case (op)
            mdu_pkg::op_mul:    full = sa * sb;
            mdu_pkg::op_mulh:   full = (sa * sb) >>> 32;
            mdu_pkg::op_mulhsu: full = (sa * zb) >>> 32;
            mdu_pkg::op_mulhu:  full = (za * zb) >> 32;
            mdu_pkg::op_div:    full = (b == 32'd0) ? -64'sd1 : overflow ? sa : sa / sb;
            mdu_pkg::op_divu:   full = (b == 32'd0) ? -64'sd1 : za / zb;
            mdu_pkg::op_rem:    full = (b == 32'd0) ? sa : overflow ? 64'sd0 : sa % sb;
            default:            full = (b == 32'd0) ? za : za % zb;
        endcase
        return full[31:0];
    endfunction

    task automatic make_request();
        logic [31:0] r;
        r       = next_rand();
        req.op  = force_op ? forced_op : mdu_pkg::mdu_op_e'(r[2:0]);
        req.tag = next_tag;
        for (int i = 0; i < mdu_pkg::num_lanes; i++) begin
            req.rs1[i] = pick_operand();
            req.rs2[i] = pick_divisor();
        end
    endtask

    task automatic record_request();
        for (int i = 0; i < mdu_pkg::num_lanes; i++) begin
            exp_data[req.tag][i] = model_lane(req.op, req.rs1[i], req.rs2[i]);
        end
        exp_op[req.tag]   = req.op;
        exp_busy[req.tag] = 1'b1;
        issued++;
        outstanding++;
    endtask

    task automatic take_response(input string phase);
        mdu_pkg::mdu_op_e op;
        string            name;
        op   = exp_op[rsp.tag];
        name = $sformatf("%s %s tag %0d", phase, op.name(), rsp.tag);
        if (!exp_busy[rsp.tag]) begin
            fail_run($sformatf("%s was answered while not outstanding", name));
        end
        check_data(name, exp_data[rsp.tag], rsp.data);
        exp_busy[rsp.tag] = 1'b0;
        outstanding--;
        last_tag = rsp.tag;
        rsp_seen = 1'b1;
    endtask

    task automatic drive_inputs(input logic want_issue, input logic ready_value);
        @(negedge clk);
        if (req_accepted) begin
            req_valid = 1'b0;
            next_tag  = next_tag + mdu_pkg::istag_t'(1);
        end
        if (req_valid) begin
            req_wait++;
            if (req_wait > 200) begin
                fail_run("request was not accepted within 200 cycles");
            end
        end else if (want_issue && outstanding < num_tags && !exp_busy[next_tag]) begin
            make_request();
            req_valid = 1'b1;
            req_wait  = 0;
        end
        rsp_ready = ready_value;
    endtask

    // Mid low phase, so both handshakes are settled for the next edge.
    task automatic sample_ports(input string phase);
        #1;
        req_accepted = req_valid && req_ready;
        if (req_accepted) begin
            record_request();
        end
        if (rsp_valid && !rsp_ready) begin
            check_flag({phase, " req_ready under stall"}, 1'b0, req_ready);
        end
        if (rsp_valid && rsp_ready) begin
            take_response(phase);
        end
    endtask

    task automatic measure_latency(input mdu_pkg::mdu_op_e op, input int expected);
        int              count;
        mdu_pkg::istag_t tag;
        string           name;
        name      = $sformatf("latency %s", op.name());
        tag       = next_tag;
        force_op  = 1'b1;
        forced_op = op;
        rsp_seen  = 1'b0;
        drive_inputs(1'b1, 1'b1);
        sample_ports(name);
        force_op = 1'b0;
        check_flag({name, " accepted"}, 1'b1, req_accepted);
        count = 0;
        while (!rsp_seen) begin
            count++;
            if (count > 4 * expected) begin
                fail_run($sformatf("%s got no response", name));
            end
            drive_inputs(1'b0, 1'b1);
            sample_ports(name);
        end
        check_latency(name, expected, count);
        check_tag(name, tag, last_tag);
    endtask

    initial begin
        int          cycles;
        int          hold_low;
        logic [31:0] r;
        rng_state    = 32'd77;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b0;
        exp_busy     = '0;
        next_tag     = '0;
        last_tag     = '0;
        forced_op    = mdu_pkg::op_mul;
        force_op     = 1'b0;
        req_accepted = 1'b0;
        rsp_seen     = 1'b0;
        issued       = 0;
        outstanding  = 0;
        req_wait     = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        drive_inputs(1'b0, 1'b0);
        sample_ports("reset");
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        check_flag("reset req_ready", 1'b1, req_ready);

        // One request at a time with the commit port open.
        for (int k = 0; k < 8; k++) begin
            measure_latency(mdu_pkg::mdu_op_e'(k[2:0]),
                            (k >= 4) ? div_cycles : mul_cycles);
        end

        cycles   = 0;
        hold_low = 0;
        while (issued < num_requests) begin
            cycles++;
            if (cycles > 40 * num_requests) begin
                fail_run("random phase did not finish in time");
            end
            r = next_rand();
            if (hold_low > 0) begin
                hold_low--;
            end else if (r[7:2] == 6'd0) begin
                // Long back-pressure stretch.
                hold_low = 8 + int'(r[11:8]);
            end
            drive_inputs(r[13:12] != 2'd0, hold_low == 0 && r[15:14] != 2'd0);
            sample_ports("random");
        end

        cycles = 0;
        while (outstanding > 0) begin
            cycles++;
            if (cycles > 100) begin
                fail_run("responses still outstanding after the drain timeout");
            end
            drive_inputs(1'b0, 1'b1);
            sample_ports("drain");
        end

        // Pipelines are empty, so any further response is a repeat.
        for (int k = 0; k < mul_cycles + div_cycles; k++) begin
            drive_inputs(1'b0, 1'b1);
            sample_ports("idle");
        end

        if (exp_busy == '0 && outstanding == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_run("scoreboard not empty after drain");
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/mdu_pkg.sv
hw/mdu_operand_prep.sv
hw/mdu_multiplier.sv
hw/mdu_divider.sv
hw/mdu_delay_line.sv
hw/mdu_commit_ctrl.sv
hw/mdu_top.sv
bench/mdu_assert.sv
bench/mdu_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mdu_tb -f filelist.f -o mdu_sim &&
./obj_dir/mdu_sim ||
{ echo "mdu simulation did not complete successfully" >&2; exit 1; }
